/* include/i2c_config.svh */
`ifndef I2C_CONFIG_SVH
`define I2C_CONFIG_SVH

// System clock feeding the controller, in Hz
`define I2C_CLK_FREQ_HZ 50_000_000

// Target SCL rate on the bus, in Hz
`define I2C_SCL_FREQ_HZ 1_000_000

// System cycles spent in each SCL half period
// One SCL period is a low half followed by a high half
`define I2C_HALF_PERIOD (`I2C_CLK_FREQ_HZ / `I2C_SCL_FREQ_HZ / 2)

`endif

/* source/i2c_bus_pkg.sv */
`include "i2c_config.svh"

package i2c_bus_pkg;

    // Counter width covers 0 .. HALF_PERIOD-1 with margin
    localparam int SCL_CNT_W = $clog2(`I2C_HALF_PERIOD + 1);

    typedef logic [7:0] i2c_byte_t;              // Data or register-address byte
    typedef logic [6:0] i2c_addr_t;              // 7-bit slave address
    typedef logic [3:0] i2c_bit_cnt_t;           // Bits 0..7 plus the acknowledge slot
    typedef logic [SCL_CNT_W-1:0] i2c_scl_cnt_t; // Half-period cycle counter

    // Bus steps handed from the sequencer to the bit engine
    typedef enum logic [2:0] {
        STEP_START     = 3'd0, // SDA falls with SCL high, ends with SCL low
        STEP_RESTART   = 3'd1, // Repeated START from SCL low
        STEP_WRITE     = 3'd2, // Eight bits out, ACK sampled in slot nine
        STEP_READ_NACK = 3'd3, // Eight bits in, master answers NACK
        STEP_STOP      = 3'd4  // SDA rises with SCL high, bus left idle
    } i2c_step_e;

endpackage

/* source/i2c_txn_pkg.sv */
package i2c_txn_pkg;

    // R/W bit as it appears in the address byte
    typedef enum logic {
        DIR_WRITE = 1'b0,
        DIR_READ  = 1'b1
    } i2c_dir_e;

    // Sequencer walk through one transaction
    typedef enum logic [3:0] {
        TXN_IDLE    = 4'd0, // Waiting for a start strobe
        TXN_START   = 4'd1, // START condition
        TXN_ADDR_W  = 4'd2, // Slave address with write bit
        TXN_PAYLOAD = 4'd3, // Data byte or register address
        TXN_RESTART = 4'd4, // Repeated START, read only
        TXN_ADDR_R  = 4'd5, // Slave address with read bit
        TXN_READ    = 4'd6, // Receive one byte and NACK it
        TXN_STOP    = 4'd7, // STOP condition, also the abort target
        TXN_FINISH  = 4'd8  // One cycle for the done handoff
    } i2c_txn_state_e;

endpackage

/* source/i2c_txn_decode.sv */
module i2c_txn_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,      // Request strobe
    input  logic                   rw,         // 0 write, 1 read
    input  i2c_bus_pkg::i2c_addr_t slave_addr,
    input  i2c_bus_pkg::i2c_byte_t data_in,    // Write data or register address
    input  logic                   step_busy,
    input  logic                   step_done,
    input  logic                   step_ack,   // High when the slave acknowledged
    output logic                   step_valid,
    output i2c_bus_pkg::i2c_step_e step_code,
    output i2c_bus_pkg::i2c_byte_t step_byte,
    output logic                   busy,
    output logic                   txn_start,
    output logic                   txn_end
);
    import i2c_bus_pkg::*;
    import i2c_txn_pkg::*;

    i2c_txn_state_e state;
    i2c_txn_state_e after_state; // Where to go once the current step completes
    i2c_dir_e       dir_q;
    i2c_addr_t      addr_q;
    i2c_byte_t      data_q;
    i2c_step_e      next_code;   // Step belonging to the current state
    i2c_byte_t      next_byte;
    logic           issued;      // Step of this state already sent to the engine

    assign busy = (state != TXN_IDLE);

    always_ff @(posedge clk) begin
        if (start && state == TXN_IDLE) begin // Latch request only when accepted
            addr_q <= slave_addr;
            dir_q  <= i2c_dir_e'(rw);
            data_q <= data_in;
        end
        if (step_valid == 1'b0 && !issued && !step_busy) begin
            step_code <= next_code;            // Held stable until the next issue
            step_byte <= next_byte;
        end
    end

    // Step table and successor for each state
    always_comb begin
        next_code   = STEP_STOP;
        next_byte   = data_q;
        after_state = TXN_IDLE;
        case (state)
            TXN_START: begin
                next_code   = STEP_START;
                after_state = TXN_ADDR_W;
            end
            TXN_ADDR_W: begin
                next_code   = STEP_WRITE;
                next_byte   = {addr_q, DIR_WRITE};            // Read also starts with a write
                after_state = step_ack ? TXN_PAYLOAD : TXN_STOP; // Address NACK aborts
            end
            TXN_PAYLOAD: begin
                next_code   = STEP_WRITE;
                after_state = (!step_ack || dir_q == DIR_WRITE) ? TXN_STOP : TXN_RESTART;
            end
            TXN_RESTART: begin
                next_code   = STEP_RESTART;
                after_state = TXN_ADDR_R;
            end
            TXN_ADDR_R: begin
                next_code   = STEP_WRITE;
                next_byte   = {addr_q, DIR_READ};
                after_state = step_ack ? TXN_READ : TXN_STOP;
            end
            TXN_READ: begin
                next_code   = STEP_READ_NACK;
                after_state = TXN_STOP;
            end
            TXN_STOP: after_state = TXN_FINISH;
            default: after_state = TXN_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= TXN_IDLE;
            issued     <= 1'b0;
            step_valid <= 1'b0;
            txn_start  <= 1'b0;
            txn_end    <= 1'b0;
        end else begin
            step_valid <= 1'b0; // All three are single-cycle pulses
            txn_start  <= 1'b0;
            txn_end    <= 1'b0;
            if (state == TXN_IDLE) begin
                if (start) begin
                    state     <= TXN_START;
                    txn_start <= 1'b1;
                    issued    <= 1'b0;
                end
            end else if (state == TXN_FINISH) begin
                state <= TXN_IDLE;                  // busy drops as done rises
            end else if (step_done) begin
                state   <= after_state;
                issued  <= 1'b0;
                txn_end <= (state == TXN_STOP);     // Final STOP has completed
            end else if (!issued && !step_busy) begin
                step_valid <= 1'b1;
                issued     <= 1'b1;
            end
        end
    end

endmodule

/* source/i2c_bit_engine.sv */
`include "i2c_config.svh"

module i2c_bit_engine (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   step_valid,
    input  i2c_bus_pkg::i2c_step_e step_code,
    input  i2c_bus_pkg::i2c_byte_t step_byte,
    output logic                   step_busy,
    output logic                   step_done,
    output logic                   step_ack,  // High when the slave pulled SDA low
    output i2c_bus_pkg::i2c_byte_t rx_byte,
    output logic                   rx_valid,
    output logic                   ack_fail,
    inout  wire                    scl,
    inout  wire                    sda
);
    import i2c_bus_pkg::*;

    localparam i2c_scl_cnt_t HALF_LAST = i2c_scl_cnt_t'(`I2C_HALF_PERIOD - 1);
    localparam i2c_bit_cnt_t ACK_SLOT  = 4'd8;  // Ninth bit of a byte step
    localparam i2c_bit_cnt_t PH_MID    = 4'd1;
    localparam i2c_bit_cnt_t PH_LAST   = 4'd2;  // Last phase of START/STOP style steps

    logic         active;     // A step is in progress
    i2c_step_e    code_q;
    i2c_bit_cnt_t ph;         // Bit index, or phase index for RESTART and STOP
    i2c_scl_cnt_t scl_cnt;
    i2c_byte_t    tx_q;       // Shifts out MSB first
    i2c_byte_t    rx_q;       // Shifts in MSB first
    logic         scl_low;    // Pull SCL low
    logic         sda_low;    // Pull SDA low
    logic         scl_in;
    logic         sda_in;
    logic         tick;       // Half-period counter may advance
    logic         half_end;   // Last cycle of a half period
    logic         low_edge;   // First cycle of a low half, SDA may change here
    logic         last_phase; // Current half period closes the step

    // Open drain, lines are only pulled low or released
    assign scl    = scl_low ? 1'b0 : 1'bz;
    assign sda    = sda_low ? 1'b0 : 1'bz;
    assign scl_in = scl;
    assign sda_in = sda;

    // Stretching: SCL released but still low freezes the count
    assign tick     = active && !(!scl_low && !scl_in);
    assign half_end = tick && (scl_cnt == HALF_LAST);
    assign low_edge = tick && scl_low && (scl_cnt == '0);

    assign step_busy = active;
    assign rx_byte   = rx_q;

    always_comb begin
        case (code_q)
            STEP_START:              last_phase = 1'b1;           // Single high half
            STEP_RESTART, STEP_STOP: last_phase = (ph == PH_LAST);
            default:                 last_phase = (ph == ACK_SLOT) && !scl_low;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scl_cnt <= '0;
        end else if (!active || half_end) begin
            scl_cnt <= '0;
        end else if (tick) begin
            scl_cnt <= scl_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (step_valid && !active) begin
            tx_q <= step_byte;
        end else if (low_edge && code_q == STEP_WRITE) begin
            tx_q <= {tx_q[6:0], 1'b0};
        end
        // Read data sampled at the end of each high half, slot nine is our NACK
        if (half_end && !scl_low && code_q == STEP_READ_NACK && ph != ACK_SLOT) begin
            rx_q <= {rx_q[6:0], sda_in};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active    <= 1'b0;
            code_q    <= STEP_START;
            ph        <= '0;
            scl_low   <= 1'b0;     // Bus released after reset
            sda_low   <= 1'b0;
            step_done <= 1'b0;
            step_ack  <= 1'b0;
            rx_valid  <= 1'b0;
            ack_fail  <= 1'b0;
        end else begin
            step_done <= 1'b0;
            rx_valid  <= 1'b0;
            ack_fail  <= 1'b0;
            if (step_valid && !active) begin
                active <= 1'b1;
                code_q <= step_code;
                ph     <= '0;
                if (step_code == STEP_START) begin
                    sda_low <= 1'b1;   // SDA falls while SCL idles high
                end
            end
            if (low_edge) begin
                case (code_q)
                    STEP_WRITE: sda_low <= (ph == ACK_SLOT) ? 1'b0 : ~tx_q[7];
                    STEP_STOP:  sda_low <= 1'b1;  // SDA low before SCL rises
                    default:    sda_low <= 1'b0;  // Released for RESTART, read data and NACK
                endcase
            end
            if (half_end) begin
                case (code_q)
                    STEP_START: scl_low <= 1'b1;
                    STEP_RESTART: begin
                        if (ph == '0) begin
                            scl_low <= 1'b0;       // SCL up with SDA high
                        end else if (ph == PH_MID) begin
                            sda_low <= 1'b1;       // Repeated START edge
                        end else begin
                            scl_low <= 1'b1;
                        end
                        ph <= ph + 1'b1;
                    end
                    STEP_STOP: begin
                        if (ph == '0) begin
                            scl_low <= 1'b0;
                        end else if (ph == PH_MID) begin
                            sda_low <= 1'b0;       // STOP edge, SCL stays released
                        end
                        ph <= ph + 1'b1;
                    end
                    default: begin
                        scl_low <= ~scl_low;       // Alternate low and high halves
                        if (!scl_low) begin
                            ph <= ph + 1'b1;       // Bit done after its high half
                        end
                    end
                endcase
                if (last_phase) begin
                    active    <= 1'b0;
                    step_done <= 1'b1;
                    step_ack  <= (code_q != STEP_WRITE) || !sda_in;
                    ack_fail  <= (code_q == STEP_WRITE) && sda_in;
                    rx_valid  <= (code_q == STEP_READ_NACK);
                end
            end
        end
    end

endmodule

/* source/i2c_result.sv */
module i2c_result (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   txn_start, // Request accepted
    input  logic                   txn_end,   // Final STOP complete
    input  logic                   rx_valid,
    input  i2c_bus_pkg::i2c_byte_t rx_byte,
    input  logic                   ack_fail,
    output i2c_bus_pkg::i2c_byte_t data_out,
    output logic                   nack,
    output logic                   done
);

    // Received byte, held across transactions that read nothing
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_out <= '0;
        end else if (rx_valid) begin
            data_out <= rx_byte;
        end
    end

    // Sticky error, cleared only when the next request is taken
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            nack <= 1'b0;
        end else if (txn_start) begin
            nack <= 1'b0;
        end else if (ack_fail) begin
            nack <= 1'b1;          // Address or data byte not acknowledged
        end
    end

    // done trails txn_end by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= txn_end;
        end
    end

endmodule

/* source/i2c_master.sv */
module i2c_master (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   rw,
    input  i2c_bus_pkg::i2c_addr_t slave_addr,
    input  i2c_bus_pkg::i2c_byte_t data_in,
    output i2c_bus_pkg::i2c_byte_t data_out,
    output logic                   busy,
    output logic                   done,
    output logic                   nack,
    inout  wire                    scl,         // Open drain, pulled up outside
    inout  wire                    sda
);

    logic                   step_valid;
    i2c_bus_pkg::i2c_step_e step_code;
    i2c_bus_pkg::i2c_byte_t step_byte;
    logic                   step_busy;
    logic                   step_done;
    logic                   step_ack;
    i2c_bus_pkg::i2c_byte_t rx_byte;
    logic                   rx_valid;
    logic                   ack_fail;
    logic                   txn_start;
    logic                   txn_end;

    // Sequencer, turns a request into bus steps
    i2c_txn_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .rw         (rw),
        .slave_addr (slave_addr),
        .data_in    (data_in),
        .step_busy  (step_busy),
        .step_done  (step_done),
        .step_ack   (step_ack),
        .step_valid (step_valid),
        .step_code  (step_code),
        .step_byte  (step_byte),
        .busy       (busy),
        .txn_start  (txn_start),
        .txn_end    (txn_end)
    );

    // Drives each step onto the wires
    i2c_bit_engine u_engine (
        .clk        (clk),
        .rst        (rst),
        .step_valid (step_valid),
        .step_code  (step_code),
        .step_byte  (step_byte),
        .step_busy  (step_busy),
        .step_done  (step_done),
        .step_ack   (step_ack),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .ack_fail   (ack_fail),
        .scl        (scl),
        .sda        (sda)
    );

    i2c_result u_result (
        .clk       (clk),
        .rst       (rst),
        .txn_start (txn_start),
        .txn_end   (txn_end),
        .rx_valid  (rx_valid),
        .rx_byte   (rx_byte),
        .ack_fail  (ack_fail),
        .data_out  (data_out),
        .nack      (nack),
        .done      (done)
    );

endmodule

/* sim/i2c_slave_model.sv */
module i2c_slave_model (
    input  logic       clk,
    input  logic [6:0] dev_addr,   // Address this model answers
    input  int         stretch,    // Cycles SCL is held low after each fall, 0 for none
    inout  wire        scl,
    inout  wire        sda
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum {S_IDLE, S_ADDR, S_WBYTE, S_READ, S_IGNORE} slave_state_e;

    logic [7:0]   mem [256];      // Register file
    logic [7:0]   ptr = 8'h00;    // Register pointer
    logic [7:0]   pend;           // Last write byte, meaning decided by RESTART or STOP
    logic         have_pend = 1'b0;
    logic [7:0]   shreg;
    logic [7:0]   tx;
    int           bit_cnt = 0;    // SCL rises seen in the current byte
    slave_state_e st = S_IDLE;
    logic         sda_low = 1'b0;
    logic         scl_hold = 1'b0;

    assign sda = sda_low ? 1'b0 : 1'bz;
    assign scl = scl_hold ? 1'b0 : 1'bz;

    // START or repeated START, a pending byte becomes the pointer
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            if (have_pend) ptr = pend;
            have_pend = 1'b0;
            st        = S_ADDR;
            bit_cnt   = 0;
            sda_low   = 1'b0;
        end
    end

    // STOP, a pending byte is stored at the pointer
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            if (have_pend) mem[ptr] = pend;
            have_pend = 1'b0;
            st        = S_IDLE;
            sda_low   = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (st != S_IDLE) begin
            if (bit_cnt < 8) shreg = {shreg[6:0], sda === 1'b0 ? 1'b0 : 1'b1};
            bit_cnt = bit_cnt + 1;
        end
    end

    always @(negedge scl) begin
        if (st != S_IDLE) begin
            if (bit_cnt == 8) begin      // Acknowledge slot begins
                case (st)
                    S_ADDR:  if (shreg[7:1] == dev_addr) sda_low = 1'b1; else st = S_IGNORE;
                    S_WBYTE: sda_low = 1'b1;
                    default: sda_low = 1'b0; // Master answers a read byte
                endcase
            end else if (bit_cnt == 9) begin
                sda_low = 1'b0;
                bit_cnt = 0;
                case (st)
                    S_ADDR: begin
                        if (shreg[0]) begin
                            st = S_READ;
                            tx = mem[ptr];
                        end else begin
                            st = S_WBYTE;
                        end
                    end
                    S_WBYTE: begin
                        pend      = shreg;
                        have_pend = 1'b1;
                    end
                    S_READ:  st = S_IGNORE;  // Single-byte reads only
                    default: st = st;
                endcase
                if (st == S_READ) sda_low = ~tx[7];
            end else if (st == S_READ) begin
                sda_low = ~tx[7 - bit_cnt];
            end
        end
    end

    // Clock stretching after every SCL fall
    always @(negedge scl) begin
        if (stretch > 0 && !scl_hold) begin
            scl_hold = 1'b1;
            repeat (stretch) @(posedge clk);
            scl_hold = 1'b0;
        end
    end

endmodule

/* sim/i2c_master_checker.sv */
module i2c_master_checker (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic done,
    input wire  scl,
    input wire  sda
);
    timeunit 1ns;
    timeprecision 1ps;

    int err_count = 0;   // Read by the testbench at the end of the run

    // Clean outputs right after reset is released
    a_reset_quiet: assert property (@(posedge clk) $fell(rst) |-> (!busy && !done))
        else begin
            err_count++;
            $error("busy or done high after reset");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            err_count++;
            $error("done held longer than one cycle");
        end

    // Idle bus is released by everyone
    a_idle_bus: assert property (@(posedge clk) disable iff (rst)
                                 !busy |-> (scl === 1'b1 && sda === 1'b1))
        else begin
            err_count++;
            $error("bus line low while idle");
        end

endmodule

bind i2c_master i2c_master_checker u_checker (
    .clk  (clk),
    .rst  (rst),
    .busy (busy),
    .done (done),
    .scl  (scl),
    .sda  (sda)
);

/* sim/i2c_master_tb.sv */
`include "i2c_config.svh"

module i2c_master_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import i2c_bus_pkg::*;

    localparam i2c_addr_t DEV    = 7'h50;
    localparam int        N_TXN  = 64;   // Transactions over all tests, with margin
    localparam longint    TIMEOUT_NS = longint'(N_TXN) * 40 * 2 * `I2C_HALF_PERIOD * 20 * 2;

    logic      clk = 1'b0;
    logic      rst;
    logic      start;
    logic      rw;
    i2c_addr_t slave_addr;
    i2c_byte_t data_in;
    i2c_byte_t data_out;
    logic      busy;
    logic      done;
    logic      nack;
    wire       scl;
    wire       sda;
    int        stretch = 0;
    int        done_count = 0;
    i2c_byte_t sb [256];     // Expected register contents

    pullup (scl);
    pullup (sda);

    always #10 clk = ~clk;

    i2c_master u_dut (
        .clk(clk), .rst(rst), .start(start), .rw(rw), .slave_addr(slave_addr),
        .data_in(data_in), .data_out(data_out), .busy(busy), .done(done),
        .nack(nack), .scl(scl), .sda(sda)
    );

    i2c_slave_model u_slave (.clk(clk), .dev_addr(DEV), .stretch(stretch), .scl(scl), .sda(sda));

    always @(negedge clk) if (!rst && done) done_count++;

    initial begin
        #(TIMEOUT_NS * 1ns);
        $display("Run timed out waiting for the DUT");
        $display("Done: errors found");
        $fatal(1, "timeout");
    end

    // A failed assertion in the bound checker stops the run right away
    always @(negedge clk) begin
        if (u_dut.u_checker.err_count != 0) begin
            $display("Bus checker assertion failed");
            $display("Done: errors found");
            $fatal(1, "assertion failure");
        end
    end

    task automatic check_byte(input string name, input i2c_byte_t exp, input i2c_byte_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("Done: errors found");
            $fatal(1, "byte mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            $display("Done: errors found");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic launch(input logic dir, input i2c_addr_t addr, input i2c_byte_t data);
        @(posedge clk);
        start      <= 1'b1;
        rw         <= dir;
        slave_addr <= addr;
        data_in    <= data;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done();
        do @(negedge clk); while (done !== 1'b1);
    endtask

    task automatic run_txn(input logic dir, input i2c_addr_t addr, input i2c_byte_t data);
        launch(dir, addr, data);
        wait_done();
    endtask

    // A read sets the slave pointer, the following write stores at it
    task automatic write_reg(input string name, input i2c_byte_t reg_a, input i2c_byte_t val);
        run_txn(1'b1, DEV, reg_a);
        check_flag(name, 1'b0, nack);
        run_txn(1'b0, DEV, val);
        check_flag(name, 1'b0, nack);
        sb[reg_a] = val;
    endtask

    task automatic read_check(input string name, input i2c_byte_t reg_a);
        run_txn(1'b1, DEV, reg_a);
        check_flag(name, 1'b0, nack);
        check_byte(name, sb[reg_a], data_out);
    endtask

    task automatic test_write_read();
        write_reg("write_read", 8'h3c, 8'h96);
        read_check("write_read", 8'h3c);
    endtask

    task automatic test_preload();
        read_check("preload", 8'h00);
        read_check("preload", 8'h7f);
        read_check("preload", 8'hff);
    endtask

    task automatic test_addr_nack();
        read_check("addr_nack", 8'h10);  // Known byte left in data_out
        run_txn(1'b1, 7'h23, 8'h10);     // Nobody answers 7'h23
        check_flag("addr_nack", 1'b1, nack);
        check_byte("addr_nack", sb[8'h10], data_out);
    endtask

    task automatic test_stretch();
        stretch = 40;                    // Longer than a half period
        write_reg("stretch", 8'h81, 8'h5a);
        read_check("stretch", 8'h81);
        stretch = 0;
    endtask

    task automatic test_start_busy();
        int count0;
        run_txn(1'b1, DEV, 8'h20);       // Pointer at 8'h20
        launch(1'b0, DEV, 8'hc3);
        count0 = done_count;             // Earlier done pulses all counted by now
        repeat (30) @(posedge clk);
        check_flag("start_busy", 1'b1, busy);
        launch(1'b0, DEV, 8'h44);        // Must be ignored
        wait_done();
        sb[8'h20] = 8'hc3;
        repeat (4 * `I2C_HALF_PERIOD) @(negedge clk);
        check_flag("start_busy", 1'b1, done_count == count0 + 1);
        read_check("start_busy", 8'h44);
        read_check("start_busy", 8'h20);
    endtask

    task automatic test_random();
        i2c_byte_t reg_a;
        i2c_byte_t val;
        for (int i = 0; i < 16; i++) begin
            reg_a = i2c_byte_t'($urandom);
            val   = i2c_byte_t'($urandom);
            write_reg("random", reg_a, val);
            read_check("random", reg_a);
        end
    endtask

    initial begin
        void'($urandom(32'h2c30));
        rst        = 1'b1;
        start      = 1'b0;
        rw         = 1'b0;
        slave_addr = '0;
        data_in    = '0;
        for (int i = 0; i < 256; i++) begin
            sb[i]          = i2c_byte_t'((i * 37 + 8'h5b) ^ (i >> 3));
            u_slave.mem[i] = sb[i];
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_write_read();
        test_preload();
        test_addr_nack();
        test_stretch();
        test_start_busy();
        test_random();
        repeat (5) @(posedge clk);
        if (u_dut.u_checker.err_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "assertion failures");
        end
    end

endmodule

/* i2c_master.f */
+incdir+include
source/i2c_bus_pkg.sv
source/i2c_txn_pkg.sv
source/i2c_txn_decode.sv
source/i2c_bit_engine.sv
source/i2c_result.sv
source/i2c_master.sv
sim/i2c_slave_model.sv
sim/i2c_master_checker.sv
sim/i2c_master_tb.sv

/* Bender.yml */
package:
  name: i2c_master

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/i2c_bus_pkg.sv
      - source/i2c_txn_pkg.sv
      - source/i2c_txn_decode.sv
      - source/i2c_bit_engine.sv
      - source/i2c_result.sv
      - source/i2c_master.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/i2c_slave_model.sv
      - sim/i2c_master_checker.sv
      - sim/i2c_master_tb.sv
